// ==== sim.f ====
+incdir+source
source/io_bridge_pkg.sv
source/req_ack_sink.sv
source/cmd_exec.sv
source/uart_tx.sv
source/io_bridge_top.sv
sim/io_bridge_chk.sv
sim/io_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the io bridge testbench with verilator and runs it into sim.log
# exit status is nonzero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

( verilator --binary --timing --assert -Wno-fatal \
    --top-module io_bridge_tb -f sim.f -o io_bridge_sim \
  && ./obj_dir/io_bridge_sim ) > sim.log 2>&1

grep -q "^ALL CHECKS PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim/io_bridge_tb.sv ====
// ========================================
// io bridge testbench
// uart line decoded here at IOB_BAUD_DIV
// switches settle 4 clocks before read-sw
// ========================================
`timescale 1ns/10ps
`default_nettype none

`include "io_bridge_defs.svh"

module io_bridge_tb;

  import io_bridge_pkg::*;

  localparam int TMO_CYC = 2000;

  logic       clk;
  logic       i_rst_n;
  logic       i_req;
  cmd_t       i_cmd;
  logic       o_ack;
  sw_t        i_sw;
  led_t       o_led;
  logic       o_uart_tx;

  integer     seed;
  int         errors;
  int         checks;
  int         err_start;
  string      test_name;
  // expected bytes in send order, decoded bytes in line order
  uart_byte_t exp_q[$];
  uart_byte_t got_q[$];
  led_t       led_model;
  int         ack_wait;
  int         max_wait;
  // complete frames seen on the line
  int         frame_cnt;
  logic       timed_out;
  string      tmo_what;

  io_bridge_top dut_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_req     (i_req),
    .i_cmd     (i_cmd),
    .o_ack     (o_ack),
    .i_sw      (i_sw),
    .o_led     (o_led),
    .o_uart_tx (o_uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================
  // compare tasks and reference
  // ========================================
  task automatic check_led(input string name, input led_t exp, input led_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s (%s): expected %h, got %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s (%s): expected %h, got %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s (%s): expected %b, got %b", test_name, name, exp, act);
    end
  endtask

  task automatic raise_timeout(input string what);
    tmo_what  = what;
    timed_out = 1'b1;
  endtask

  // ends the run once any wait gives up
  initial begin : watchdog
    wait (timed_out === 1'b1);
    $display("timeout in %s: %s", test_name, tmo_what);
    $display("CHECKS FAILED");
    $finish;
  end

  // led model and optional uart byte for one command
  function automatic void expect_result(input cmd_t c, input sw_t sw, input led_t led_now,
                                        output led_t led_exp, output logic has_byte,
                                        output uart_byte_t byte_exp);
    string digits;
    digits   = "0123456789ABCDEF";
    led_exp  = led_now;
    has_byte = 1'b0;
    byte_exp = 8'h00;
    case (c.op)
      OP_LED: led_exp = c.data;
      OP_ECHO: begin
        has_byte = 1'b1;
        byte_exp = c.data;
      end
      OP_READ_SW: begin
        has_byte = 1'b1;
        byte_exp = digits[sw];
      end
      default: has_byte = 1'b0;
    endcase
  endfunction

  function automatic cmd_t make_cmd(input op_e op, input logic [7:0] data);
    cmd_t c;
    c.op   = op;
    c.data = data;
    return c;
  endfunction

  // ========================================
  // host side handshake
  // ========================================
  // call just after a rising edge
  // waited counts cycles until ack
  task automatic send_cmd(input cmd_t c, output int waited);
    int t;
    t = 0;
    while (o_ack !== 1'b0) begin
      if (t == TMO_CYC) raise_timeout("ack still high from last command");
      @(posedge clk);
      t++;
    end
    i_cmd  <= c;
    i_req  <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (o_ack !== 1'b1) begin
      if (waited == TMO_CYC) raise_timeout("no ack for request");
      @(posedge clk);
      waited++;
    end
    i_req <= 1'b0;
    t = 0;
    // transfer ends on ack falling
    while (o_ack !== 1'b0) begin
      if (t == TMO_CYC) raise_timeout("ack did not fall after request dropped");
      @(posedge clk);
      t++;
    end
  endtask

  task automatic run_cmd(input cmd_t c);
    led_t       led_exp;
    logic       has_byte;
    uart_byte_t b;
    expect_result(c, i_sw, led_model, led_exp, has_byte, b);
    led_model = led_exp;
    if (has_byte) exp_q.push_back(b);
    send_cmd(c, ack_wait);
    if (ack_wait > max_wait) max_wait = ack_wait;
  endtask

  task automatic wait_led(input string name);
    int t;
    t = 0;
    while (o_led !== led_model && t < TMO_CYC) begin
      @(posedge clk);
      t++;
    end
    check_led(name, led_model, o_led);
  endtask

  task automatic wait_uart_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 || got_q.size() != 0) begin
      if (t == TMO_CYC) raise_timeout("expected uart frames did not arrive");
      @(posedge clk);
      t++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    $display("test %s: %0d errors", test_name, errors - err_start);
  endtask

  // ========================================
  // uart decoder and byte compare
  // ========================================
  // falling start edge, then mid-bit samples on the falling clock
  initial begin : uart_decode
    uart_byte_t b;
    forever begin
      @(negedge clk);
      if (i_rst_n && o_uart_tx === 1'b0) begin
        repeat (`IOB_BAUD_DIV / 2 - 1) @(negedge clk);
        if (o_uart_tx !== 1'b0) begin
          errors++;
          $display("frame error in %s: start bit not low at its middle", test_name);
        end
        for (int i = 0; i < 8; i++) begin
          repeat (`IOB_BAUD_DIV) @(negedge clk);
          b[i] = o_uart_tx;
        end
        repeat (`IOB_BAUD_DIV) @(negedge clk);
        if (o_uart_tx !== 1'b1) begin
          errors++;
          $display("frame error in %s: stop bit not high", test_name);
        end
        frame_cnt++;
        got_q.push_back(b);
      end
    end
  end

  initial begin : compare_bytes
    uart_byte_t got_b;
    uart_byte_t exp_b;
    forever begin
      @(negedge clk);
      if (got_q.size() > 0) begin
        got_b = got_q.pop_front();
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected uart frame in %s, byte %h", test_name, got_b);
        end else begin
          exp_b = exp_q.pop_front();
          check_byte("uart byte", exp_b, got_b);
        end
      end
    end
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin : main_flow
    op_e mix [0:7];
    sw_t sw_vals [0:3];
    int  idle_low;
    int  frames_before;
    i_rst_n   = 1'b1;
    i_req     = 1'b0;
    i_cmd     = '0;
    i_sw      = '0;
    seed      = 32'h3018_0240;
    errors    = 0;
    checks    = 0;
    led_model = '0;
    max_wait  = 0;
    frame_cnt = 0;
    timed_out = 1'b0;
    test_name = "reset_state";
    mix       = '{OP_ECHO, OP_READ_SW, OP_LED, OP_ECHO, OP_ECHO, OP_LED, OP_READ_SW, OP_ECHO};
    sw_vals   = '{4'd0, 4'd9, 4'd10, 4'd15};
    // reset edge lands before the first clock
    #1 i_rst_n = 1'b0;
    repeat (4) @(posedge clk);
    i_rst_n <= 1'b1;

    begin_test("reset_state");
    @(posedge clk);
    check_flag("ack after reset", 1'b0, o_ack);
    check_led("led after reset", '0, o_led);
    idle_low = 0;
    repeat (50) begin
      @(posedge clk);
      if (o_uart_tx !== 1'b1) idle_low++;
    end
    check_flag("line idle after reset", 1'b1, idle_low == 0);
    end_test();

    begin_test("led_write");
    repeat (6) begin
      run_cmd(make_cmd(OP_LED, 8'($random(seed))));
      wait_led("led value");
    end
    end_test();

    begin_test("echo");
    repeat (4) begin
      run_cmd(make_cmd(OP_ECHO, 8'($random(seed))));
      wait_uart_drain();
    end
    end_test();

    begin_test("switch_report");
    for (int i = 0; i < 4; i++) begin
      i_sw <= sw_vals[i];
      // room for the two-flop synchronizer
      repeat (4) @(posedge clk);
      run_cmd(make_cmd(OP_READ_SW, 8'h00));
      wait_uart_drain();
    end
    end_test();

    begin_test("back_pressure");
    max_wait = 0;
    for (int i = 0; i < 8; i++) begin
      run_cmd(make_cmd(mix[i], 8'($random(seed))));
    end
    check_flag("later ack delayed", 1'b1, max_wait > 2 * `IOB_BAUD_DIV);
    wait_uart_drain();
    wait_led("final led");
    end_test();

    begin_test("no_op");
    frames_before = frame_cnt;
    run_cmd(make_cmd(OP_NOP, 8'($random(seed))));
    // one frame time plus margin
    repeat (10 * `IOB_BAUD_DIV + 40) @(posedge clk);
    check_led("led after nop", led_model, o_led);
    check_flag("no frame after nop", 1'b1, frame_cnt == frames_before);
    end_test();

    errors += int'(dut_i.chk_i.fail_cnt);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/io_bridge_chk.sv ====
// ========================================
// protocol checker, bound into the top
// samples on the rising clock edge
// ========================================
`timescale 1ns/10ps
`default_nettype none

module io_bridge_chk (
  input wire                 clk,
  input wire                 i_rst_n,
  input wire                 i_req,
  input io_bridge_pkg::cmd_t i_cmd,
  input wire                 i_ack,
  input wire                 i_uart_tx
);

  // failure count, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // ack only rises in answer to a request
  ack_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
    (!i_req && !i_ack) |=> !i_ack)
    else begin
      fail_cnt++;
      $error("o_ack rose while i_req was low");
    end

  // ack held for as long as req is up
  ack_holds: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_req && i_ack) |=> i_ack)
    else begin
      fail_cnt++;
      $error("o_ack dropped while i_req was high");
    end

  // line idles high in reset
  idle_in_reset: assert property (@(posedge clk) !i_rst_n |-> i_uart_tx)
    else begin
      fail_cnt++;
      $error("o_uart_tx low during reset");
    end

  // host keeps the command steady until acked
  cmd_steady: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_req && !i_ack && $past(i_req)) |-> $stable(i_cmd))
    else begin
      fail_cnt++;
      $error("i_cmd changed while waiting for ack");
    end

endmodule

bind io_bridge_top io_bridge_chk chk_i (
  .clk       (clk),
  .i_rst_n   (i_rst_n),
  .i_req     (i_req),
  .i_cmd     (i_cmd),
  .i_ack     (o_ack),
  .i_uart_tx (o_uart_tx)
);

`default_nettype wire

// ==== source/io_bridge_top.sv ====
// ========================================
// io bridge top
// sink -> executor -> uart, one cmd each
// back-pressure reaches the host as late ack
// ========================================
`timescale 1ns/10ps
`default_nettype none

module io_bridge_top (
  input  wire                  clk,
  input  wire                  i_rst_n,
  input  wire                  i_req,
  input  io_bridge_pkg::cmd_t  i_cmd,
  output logic                 o_ack,
  input  io_bridge_pkg::sw_t   i_sw,
  output io_bridge_pkg::led_t  o_led,
  output logic                 o_uart_tx
);

  import io_bridge_pkg::*;

  // sink to executor
  logic       cmd_valid;
  logic       cmd_ready;
  cmd_t       cmd;
  // executor to uart
  logic       tx_valid;
  logic       tx_ready;
  uart_byte_t tx_byte;

  req_ack_sink sink_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .i_cmd       (i_cmd),
    .o_ack       (o_ack),
    .o_cmd_valid (cmd_valid),
    .o_cmd       (cmd),
    .i_cmd_ready (cmd_ready)
  );

  cmd_exec exec_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (cmd_valid),
    .i_cmd       (cmd),
    .o_cmd_ready (cmd_ready),
    .i_sw        (i_sw),
    .o_led       (o_led),
    .o_tx_valid  (tx_valid),
    .o_tx_byte   (tx_byte),
    .i_tx_ready  (tx_ready)
  );

  uart_tx uart_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_tx_valid (tx_valid),
    .i_tx_byte  (tx_byte),
    .o_tx_ready (tx_ready),
    .o_uart_tx  (o_uart_tx)
  );

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// ========================================
// 8N1 uart transmitter, LSB first
// bit time is IOB_BAUD_DIV clocks
// start bit begins the cycle after accept
// line idles high, also in reset
// ========================================
`timescale 1ns/10ps
`default_nettype none

`include "io_bridge_defs.svh"

module uart_tx (
  input  wire                       clk,
  input  wire                       i_rst_n,
  input  wire                       i_tx_valid,
  input  io_bridge_pkg::uart_byte_t i_tx_byte,
  output logic                      o_tx_ready,
  output logic                      o_uart_tx
);

  localparam int BAUD_W = $clog2(`IOB_BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`IOB_BAUD_DIV - 1);

  logic              busy_q;
  logic              line_q;
  logic [BAUD_W-1:0] baud_cnt_q;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]        bit_cnt_q;
  // remaining data bits with stop bit on top
  logic [8:0]        shift_q;
  logic              start;
  logic              baud_tick;

  assign start     = i_tx_valid && !busy_q;
  assign baud_tick = busy_q && (baud_cnt_q == BAUD_LAST);

  // ========================================
  // frame sequencing
  // ========================================
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy_q     <= 1'b0;
      line_q     <= 1'b1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (start) begin
      // start bit
      busy_q     <= 1'b1;
      line_q     <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (baud_tick) begin
      baud_cnt_q <= '0;
      if (bit_cnt_q == 4'd9) begin
        // stop bit done, back to idle
        busy_q <= 1'b0;
        line_q <= 1'b1;
      end else begin
        line_q    <= shift_q[0];
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
    end else if (busy_q) begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  // shifter, ones fill in behind the stop bit
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= {1'b1, i_tx_byte};
    end else if (baud_tick) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  assign o_tx_ready = !busy_q;
  assign o_uart_tx  = line_q;

endmodule

`default_nettype wire

// ==== source/cmd_exec.sv ====
// ========================================
// command executor
// switches pass a 2-flop synchronizer
// read-sw gives one ASCII hex digit 0-9 A-F
// stalls while the byte register is full
// ========================================
`timescale 1ns/10ps
`default_nettype none

module cmd_exec (
  input  wire                       clk,
  input  wire                       i_rst_n,
  input  wire                       i_cmd_valid,
  input  io_bridge_pkg::cmd_t       i_cmd,
  output logic                      o_cmd_ready,
  input  io_bridge_pkg::sw_t        i_sw,
  output io_bridge_pkg::led_t       o_led,
  output logic                      o_tx_valid,
  output io_bridge_pkg::uart_byte_t o_tx_byte,
  input  wire                       i_tx_ready
);

  import io_bridge_pkg::*;

  sw_t        sw_meta_q;
  sw_t        sw_sync_q;
  led_t       led_q;
  logic       tx_valid_q;
  uart_byte_t tx_byte_q;
  logic       accept;

  // nibble to ASCII hex, upper case letters
  function automatic uart_byte_t hex_char(input sw_t nib);
    uart_byte_t wide;
    wide = uart_byte_t'(nib);
    if (wide < 8'd10) begin
      return 8'h30 + wide;
    end
    return 8'h37 + wide;
  endfunction

  // one byte in flight at most
  assign o_cmd_ready = !tx_valid_q;
  assign accept      = i_cmd_valid && o_cmd_ready;

  // ========================================
  // control state and led bank
  // ========================================
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sw_meta_q  <= '0;
      sw_sync_q  <= '0;
      led_q      <= '0;
      tx_valid_q <= 1'b0;
    end else begin
      // switch synchronizer
      sw_meta_q <= i_sw;
      sw_sync_q <= sw_meta_q;
      if (accept) begin
        unique case (i_cmd.op)
          OP_LED:     led_q      <= led_t'(i_cmd.data);
          OP_ECHO:    tx_valid_q <= 1'b1;
          OP_READ_SW: tx_valid_q <= 1'b1;
          // nop just drains the slot
          default:    tx_valid_q <= 1'b0;
        endcase
      end else if (i_tx_ready) begin
        // uart took the byte
        tx_valid_q <= 1'b0;
      end
    end
  end

  // output byte, no reset
  always_ff @(posedge clk) begin
    if (accept && i_cmd.op == OP_ECHO) begin
      tx_byte_q <= i_cmd.data;
    end else if (accept && i_cmd.op == OP_READ_SW) begin
      tx_byte_q <= hex_char(sw_sync_q);
    end
  end

  assign o_led      = led_q;
  assign o_tx_valid = tx_valid_q;
  assign o_tx_byte  = tx_byte_q;

endmodule

`default_nettype wire

// ==== source/req_ack_sink.sv ====
// ========================================
// four-phase req/ack receiver, one slot
// i_cmd must be stable while i_req is high
// new request taken only with slot empty
// ========================================
`timescale 1ns/10ps
`default_nettype none

module req_ack_sink (
  input  wire                  clk,
  input  wire                  i_rst_n,
  input  wire                  i_req,
  input  io_bridge_pkg::cmd_t  i_cmd,
  output logic                 o_ack,
  output logic                 o_cmd_valid,
  output io_bridge_pkg::cmd_t  o_cmd,
  input  wire                  i_cmd_ready
);

  import io_bridge_pkg::*;

  logic ack_q;
  logic valid_q;
  cmd_t cmd_q;
  logic capture;

  // new request: req up, ack down, slot free
  assign capture = i_req && !ack_q && !valid_q;

  // ========================================
  // handshake and slot state
  // ========================================
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ack_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      // ack follows req low, rises only on capture
      if (capture) begin
        ack_q <= 1'b1;
      end else if (!i_req) begin
        ack_q <= 1'b0;
      end
      // slot fills on capture, drains on downstream transfer
      if (capture) begin
        valid_q <= 1'b1;
      end else if (i_cmd_ready) begin
        valid_q <= 1'b0;
      end
    end
  end

  // command payload, no reset
  always_ff @(posedge clk) begin
    if (capture) begin
      cmd_q <= i_cmd;
    end
  end

  assign o_ack       = ack_q;
  assign o_cmd_valid = valid_q;
  assign o_cmd       = cmd_q;

endmodule

`default_nettype wire

// ==== source/io_bridge_pkg.sv ====
// ========================================
// shared types of the io bridge
// cmd_t is 10 bits, op in the upper two
// ========================================
`default_nettype none

`include "io_bridge_defs.svh"

package io_bridge_pkg;

  // host opcodes
  typedef enum logic [1:0] {
    OP_NOP     = 2'd0,
    OP_LED     = 2'd1,
    OP_ECHO    = 2'd2,
    OP_READ_SW = 2'd3
  } op_e;

  // one host command, as carried over req/ack
  typedef struct packed {
    op_e        op;
    logic [7:0] data;
  } cmd_t;

  // led bank and switch values
  typedef logic [`IOB_LED_W-1:0] led_t;
  typedef logic [`IOB_SW_W-1:0]  sw_t;

  // uart payload
  typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire

// ==== source/io_bridge_defs.svh ====
// ========================================
// io bridge build constants
// IOB_BAUD_DIV must be at least 2
// IOB_LED_W matches the 8-bit command data
// IOB_SW_W is 4, one hex digit on the UART
// ========================================
`ifndef IO_BRIDGE_DEFS_SVH
`define IO_BRIDGE_DEFS_SVH

// clock cycles per uart bit, kept short for simulation
`define IOB_BAUD_DIV 16

// led bank width
`define IOB_LED_W 8

// dip switch width
`define IOB_SW_W 4

`endif
